/* hw/axi_read_master.sv */
// --------------------------------------
// AXI read master for instruction bursts
// AR/R control, beat count, error flag
// --------------------------------------
module axi_read_master (
    input  logic                                 clk,
    input  logic                                 rst_n,
    fetch_if.mst                                 fetch,
    // AR channel
    output logic [ifu_pkg::AXI_ADDR_WIDTH-1:0]   araddr,
    output logic                                 arvalid,
    input  logic                                 arready,
    // R channel
    input  logic [ifu_pkg::AXI_DATA_WIDTH-1:0]   rdata,
    input  logic [ifu_pkg::AXI_RESP_WIDTH-1:0]   rresp,
    input  logic                                 rlast,
    input  logic                                 rvalid,
    output logic                                 rready,
    // instruction stream
    output logic [ifu_pkg::CPU_WIDTH-1:0]        inst,
    output logic [ifu_pkg::CPU_WIDTH-1:0]        inst_pc,
    output logic                                 inst_valid,
    output logic                                 fetch_error
);

    ifu_pkg::rd_state_t                   state;
    logic [ifu_pkg::BEAT_CNT_WIDTH-1:0]   beat_cnt;
    logic [ifu_pkg::CPU_WIDTH-1:0]        beat_ofs;  // byte offset of current beat
    logic                                 r_fire;

    assign r_fire   = rvalid && rready;
    assign beat_ofs = ifu_pkg::BEAT_BYTES * beat_cnt;

    // ----------------------------------------
    // read FSM, owns arvalid and rready
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ifu_pkg::RD_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            case (state)
                ifu_pkg::RD_IDLE: begin
                    if (fetch.req) begin
                        state   <= ifu_pkg::RD_ADDR;
                        arvalid <= 1'b1;
                    end
                end
                ifu_pkg::RD_ADDR: begin
                    if (arready) begin  // address accepted
                        state   <= ifu_pkg::RD_DATA;
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                end
                ifu_pkg::RD_DATA: begin
                    if (r_fire && rlast) begin
                        state  <= ifu_pkg::RD_IDLE;
                        rready <= 1'b0;
                    end
                end
                default: begin
                    state   <= ifu_pkg::RD_IDLE;
                    arvalid <= 1'b0;
                    rready  <= 1'b0;
                end
            endcase
        end
    end

    // bus address captured once per burst
    always_ff @(posedge clk) begin
        if (state == ifu_pkg::RD_IDLE && fetch.req) begin
            araddr <= ifu_pkg::INST_MEM_BASE_ADDR + fetch.addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (r_fire) begin
            beat_cnt <= rlast ? '0 : beat_cnt + 1'b1;  // rlast rearms for next burst
        end
    end

    // ----------------------------------------
    // instruction delivery, one cycle after beat
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_valid  <= 1'b0;
            fetch_error <= 1'b0;
        end else begin
            inst_valid  <= r_fire;
            fetch_error <= r_fire && rresp[ifu_pkg::AXI_RESP_WIDTH-1];  // slverr or decerr
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            inst    <= rdata;
            inst_pc <= fetch.addr + beat_ofs;
        end
    end

    assign fetch.busy     = (state != ifu_pkg::RD_IDLE);
    assign fetch.done     = r_fire && rlast;
    assign fetch.beat_idx = beat_cnt;

    // AR payload must hold while the slave stalls
    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    a_rready_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == ifu_pkg::RD_IDLE |-> !rready
    );

    // sequencer never requests over an open burst
    a_req_when_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch.req |-> !fetch.busy
    );

endmodule

/* hw/fetch_if.sv */
// --------------------------------------
// fetch request link between the pc
// sequencer and the AXI read master
// --------------------------------------
interface fetch_if;

    logic                                 req;       // one-cycle fetch pulse
    logic [ifu_pkg::CPU_WIDTH-1:0]        addr;      // pc of the open fetch
    logic                                 busy;      // master has a burst open
    logic                                 done;      // last beat accepted
    logic [ifu_pkg::BEAT_CNT_WIDTH-1:0]   beat_idx;  // beat position in burst

    // pc side
    modport seq (
        output req,
        output addr,
        input  done
    );

    // bus side
    modport mst (
        input  req,
        input  addr,
        output busy,
        output done,
        output beat_idx
    );

endinterface

/* hw/ifu_pkg.sv */
// --------------------------------------
// shared widths, burst constants, reset PC
// and the read-master state encoding
// --------------------------------------
package ifu_pkg;

    // ----------------------------------------
    // datapath widths
    // ----------------------------------------
    localparam int CPU_WIDTH      = 32;  // pc and instruction
    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;  // one beat is one instruction
    localparam int AXI_RESP_WIDTH = 2;   // upper bit set means SLVERR or DECERR

    // ----------------------------------------
    // burst shape agreed with the slave
    // ----------------------------------------
    // INCR bursts, id 0, FETCH_BURST_LEN beats of 4 bytes
    localparam int FETCH_BURST_LEN = 4;
    localparam int BEAT_CNT_WIDTH  = (FETCH_BURST_LEN > 1) ? $clog2(FETCH_BURST_LEN) : 1;

    localparam logic [CPU_WIDTH-1:0] BEAT_BYTES  = 32'd4;
    localparam logic [CPU_WIDTH-1:0] BURST_BYTES = FETCH_BURST_LEN * BEAT_BYTES;  // pc step

    // ----------------------------------------
    // address map
    // ----------------------------------------
    localparam logic [AXI_ADDR_WIDTH-1:0] INST_MEM_BASE_ADDR = 32'h0000_1000;
    localparam logic [CPU_WIDTH-1:0]      RESET_PC           = 32'h0000_0000;

    // read master FSM
    typedef enum logic [1:0] {
        RD_IDLE,  // waiting for a fetch request
        RD_ADDR,  // arvalid up, waiting for arready
        RD_DATA   // collecting beats until rlast
    } rd_state_t;

endpackage

/* hw/ifu_top.sv */
// --------------------------------------
// instruction fetch unit top level
// pc sequencer plus AXI read master
// --------------------------------------
module ifu_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 enable,  // fetch run control
    // ----------------------------------------
    // AXI read address channel
    // ----------------------------------------
    output logic [ifu_pkg::AXI_ADDR_WIDTH-1:0]   araddr,
    output logic                                 arvalid,
    input  logic                                 arready,
    // ----------------------------------------
    // AXI read data channel
    // ----------------------------------------
    input  logic [ifu_pkg::AXI_DATA_WIDTH-1:0]   rdata,
    input  logic [ifu_pkg::AXI_RESP_WIDTH-1:0]   rresp,
    input  logic                                 rlast,
    input  logic                                 rvalid,
    output logic                                 rready,
    // ----------------------------------------
    // fetched instruction stream
    // ----------------------------------------
    output logic [ifu_pkg::CPU_WIDTH-1:0]        inst,
    output logic [ifu_pkg::CPU_WIDTH-1:0]        inst_pc,
    output logic                                 inst_valid,   // no back-pressure
    output logic                                 fetch_error   // flags the same beat
);

    // req/addr one way, busy/done/beat_idx back
    fetch_if u_fetch ();

    pc_sequencer u_pc_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .fetch      (u_fetch.seq)
    );

    axi_read_master u_axi_read_master (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch       (u_fetch.mst),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_valid  (inst_valid),
        .fetch_error (fetch_error)
    );

endmodule

/* hw/pc_sequencer.sv */
// --------------------------------------
// program counter with sequential next-pc
// and single outstanding fetch gating
// --------------------------------------
module pc_sequencer (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  enable,
    fetch_if.seq  fetch
);

    logic [ifu_pkg::CPU_WIDTH-1:0] pc;
    logic                          req_q;
    logic                          fetch_open;  // burst requested, done not yet seen
    logic                          can_start;

    // a new fetch may follow directly on the done pulse
    assign can_start = enable && !req_q && (!fetch_open || fetch.done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= can_start;  // single cycle, req_q blocks a repeat
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_open <= 1'b0;
        end else if (req_q) begin
            fetch_open <= 1'b1;
        end else if (fetch.done) begin
            fetch_open <= 1'b0;
        end
    end

    // ----------------------------------------
    // pc register, sequential only
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= ifu_pkg::RESET_PC;
        end else if (fetch.done) begin
            pc <= pc + ifu_pkg::BURST_BYTES;  // step over the whole burst
        end
    end

    assign fetch.req  = req_q;
    assign fetch.addr = pc;  // held until done

    // at most one fetch outstanding
    a_req_not_open: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch.req |-> !fetch_open
    );

endmodule

/* ifu_top.f */
hw/ifu_pkg.sv
hw/fetch_if.sv
hw/pc_sequencer.sv
hw/axi_read_master.sv
hw/ifu_top.sv
testbench/axi_rd_slave_model.sv
testbench/tb_ifu_top.sv

/* run_sim.sh */
#!/bin/sh
# build the fetch unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_ifu_top
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --top-module "$TOP" -f ifu_top.f -o "V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "no pass report found in $LOG"
exit 1

/* testbench/axi_rd_slave_model.sv */
// ----------------------------------------
// behavioral AXI read slave
// arready delay, idle gaps between beats
// and one optional SLVERR beat per burst
// ----------------------------------------
module axi_rd_slave_model (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [ifu_pkg::AXI_ADDR_WIDTH-1:0]  araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [ifu_pkg::AXI_DATA_WIDTH-1:0]  rdata,
    output logic [ifu_pkg::AXI_RESP_WIDTH-1:0]  rresp,
    output logic                                rlast,
    output logic                                rvalid,
    input  logic                                rready,
    input  int                                  ar_delay,  // cycles before arready
    input  int                                  beat_gap,  // idle cycles ahead of each beat
    input  int                                  err_beat   // -1 for a clean burst
);

    localparam logic [31:0] WORD_XOR = 32'hA5A5_0000;  // word at A is A ^ this

    logic [31:0] burst_addr;
    int          gap;
    int          err;
    int          beat;

    task automatic next_drive_point();
        @(posedge clk);
        #1;
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        rresp   = '0;
        forever begin
            @(negedge clk);
            if (rst_n && arvalid) begin
                burst_addr = araddr;
                gap        = beat_gap;
                err        = err_beat;
                repeat (ar_delay + 1) next_drive_point();
                arready = 1'b1;
                next_drive_point();  // address taken on this edge
                arready = 1'b0;
                // INCR burst, 4 bytes per beat
                for (beat = 0; beat < ifu_pkg::FETCH_BURST_LEN; beat++) begin
                    repeat (gap) next_drive_point();
                    rvalid = 1'b1;
                    rdata  = (burst_addr + ifu_pkg::BEAT_BYTES * beat) ^ WORD_XOR;
                    rresp  = (beat == err) ? 2'b10 : 2'b00;  // slverr
                    rlast  = (beat == ifu_pkg::FETCH_BURST_LEN - 1);
                    @(negedge clk);
                    while (!rready) @(negedge clk);
                    next_drive_point();
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                    rresp  = '0;
                end
            end
        end
    end

endmodule

/* testbench/tb_ifu_top.sv */
// ----------------------------------------
// testbench for the instruction fetch unit
// fetch table, clock, reset, checks
// against the memory rule, watchdog, report
// ----------------------------------------
module tb_ifu_top;

    localparam int NUM_ROWS       = 8;
    localparam int RESET_CYCLES   = 4;
    localparam int IDLE_CYCLES    = 6;  // window with enable low
    localparam int ENABLE_LATENCY = 3;  // negedges from enable drive to arvalid
    localparam int CHAIN_LATENCY  = 1;  // negedges from last beat out to next arvalid
    localparam int MAX_GAP        = 3;  // also bounds the random gaps
    localparam int MAX_AR_DELAY   = 5;
    localparam int WATCHDOG_CYCLES =
        NUM_ROWS * (ifu_pkg::FETCH_BURST_LEN * MAX_GAP + MAX_AR_DELAY + 10);
    localparam logic [31:0] WORD_XOR = 32'hA5A5_0000;

    typedef struct {
        int ar_delay;
        int beat_gap;      // -1 draws from $random
        int err_beat;      // -1 for a clean burst
        bit enable_after;
    } row_t;

    logic                                clk;
    logic                                rst_n;
    logic                                enable;
    logic [ifu_pkg::AXI_ADDR_WIDTH-1:0]  araddr;
    logic                                arvalid, arready;
    logic [ifu_pkg::AXI_DATA_WIDTH-1:0]  rdata;
    logic [ifu_pkg::AXI_RESP_WIDTH-1:0]  rresp;
    logic                                rlast, rvalid, rready;
    logic [ifu_pkg::CPU_WIDTH-1:0]       inst, inst_pc;
    logic                                inst_valid, fetch_error;
    int                                  ar_delay, beat_gap, err_beat;

    row_t        rows [NUM_ROWS];
    logic [31:0] exp_pc;  // pc the next fetch must carry
    int          seed;
    int          test_errors;
    int          tests_ok;
    int          tests_bad;

    ifu_top UUT (.*);
    axi_rd_slave_model u_slave (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: fetch sequence still running after %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic next_drive_point();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ WORD_XOR;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at time %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic require(input bit cond, input string what);
        assert (cond) else begin
            $display("Error at time %0t: %s", $time, what);
            test_errors++;
        end
    endtask

    task automatic expect_bus_idle();
        compare_value("arvalid", 32'(arvalid), 32'd0);
        compare_value("rready", 32'(rready), 32'd0);
        compare_value("inst_valid", 32'(inst_valid), 32'd0);
        compare_value("fetch_error", 32'(fetch_error), 32'd0);
    endtask

    task automatic close_test(input string label);
        if (test_errors == 0) begin
            tests_ok++;
            $display("%s: ok", label);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", label, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic set_row(input int idx, input int ar, input int gap, input int err,
                           input bit en);
        rows[idx].ar_delay     = ar;
        rows[idx].beat_gap     = gap;
        rows[idx].err_beat     = err;
        rows[idx].enable_after = en;
    endtask

    // ----------------------------------------
    // one table row is one burst
    // ----------------------------------------
    task automatic run_fetch(input int row);
        int          gap;
        int          waited;
        int          beats;
        bit          from_idle;
        logic [31:0] exp_addr;
        logic [31:0] beat_ofs;
        gap = rows[row].beat_gap;
        if (gap < 0) begin
            gap = {$random(seed)} % (MAX_GAP + 1);
        end
        ar_delay  = rows[row].ar_delay;
        beat_gap  = gap;
        err_beat  = rows[row].err_beat;
        exp_addr  = ifu_pkg::INST_MEM_BASE_ADDR + exp_pc;
        from_idle = !enable;
        if (from_idle) begin
            next_drive_point();
            enable = 1'b1;
        end

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            compare_value("inst_valid", 32'(inst_valid), 32'd0);  // no beat outside a burst
        end while (!arvalid);
        if (from_idle) begin
            require(waited == ENABLE_LATENCY, "arvalid did not follow enable by two cycles");
        end else begin
            require(waited == CHAIN_LATENCY,
                    "arvalid did not follow the previous last beat by two cycles");
        end
        compare_value("araddr", araddr, exp_addr);
        while (!arready) begin
            @(negedge clk);
            compare_value("arvalid", 32'(arvalid), 32'd1);
            compare_value("araddr", araddr, exp_addr);
        end
        next_drive_point();  // just past the AR handshake
        enable = rows[row].enable_after;

        beats = 0;
        while (beats < ifu_pkg::FETCH_BURST_LEN) begin
            @(negedge clk);
            compare_value("arvalid", 32'(arvalid), 32'd0);
            if (inst_valid) begin
                beat_ofs = ifu_pkg::BEAT_BYTES * beats;
                compare_value("inst", inst, mem_word(exp_addr + beat_ofs));
                compare_value("inst_pc", inst_pc, exp_pc + beat_ofs);
                compare_value("fetch_error", 32'(fetch_error), 32'(beats == err_beat));
                beats++;
            end else begin
                compare_value("fetch_error", 32'(fetch_error), 32'd0);
            end
        end

        // bus stays quiet while enable is low
        if (!rows[row].enable_after) begin
            repeat (IDLE_CYCLES) begin
                @(negedge clk);
                expect_bus_idle();
            end
        end
        close_test($sformatf("row %0d, pc 0x%08h, ar_delay %0d, gap %0d, err_beat %0d",
                             row, exp_pc, rows[row].ar_delay, gap, rows[row].err_beat));
        exp_pc = exp_pc + ifu_pkg::BURST_BYTES;
    endtask

    initial begin
        int row;
        seed        = 46682;
        rst_n       = 1'b0;
        enable      = 1'b0;
        ar_delay    = 0;
        beat_gap    = 0;
        err_beat    = -1;
        exp_pc      = ifu_pkg::RESET_PC;
        test_errors = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        set_row(0, 0, 0, -1, 1'b1);   // plain back to back
        set_row(1, 3, 0, -1, 1'b1);   // arready held off
        set_row(2, 0, 2, 1, 1'b1);
        set_row(3, 1, -1, -1, 1'b0);  // enable drops mid burst
        set_row(4, 0, 0, 3, 1'b1);    // error on the rlast beat
        set_row(5, 5, -1, 0, 1'b1);
        set_row(6, 2, 3, -1, 1'b0);
        set_row(7, 0, -1, 2, 1'b0);

        repeat (RESET_CYCLES) begin
            next_drive_point();
            expect_bus_idle();
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            expect_bus_idle();
        end
        close_test("reset");

        for (row = 0; row < NUM_ROWS; row++) begin
            run_fetch(row);
        end

        $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
